// ==== hw/ifetch_pkg.sv ====
// Instruction fetch read merge shared definitions
// Bus field widths, the read address and read beat payloads
// and the tag that names which master owns a request

package ifetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths

	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int ID_W    = 4;
	localparam int LEN_W   = 8;  // Beats per burst minus one
	localparam int SIZE_W  = 3;
	localparam int BURST_W = 2;
	localparam int RESP_W  = 2;

	////////////////////////////////////////////////////////////////////////////
	// Channel payloads

	// Read address request, valid and ready travel beside it
	typedef struct packed
	{
		logic [ID_W-1:0]    id;
		logic [ADDR_W-1:0]  addr;
		logic [LEN_W-1:0]   len;
		logic [SIZE_W-1:0]  size;
		logic [BURST_W-1:0] burst;
	} ar_req_t;

	// One beat of read data
	typedef struct packed
	{
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		logic              last;  // Final beat of the burst
	} r_beat_t;

	// Owner of a read request
	typedef enum logic
	{
		SRC_UNCACHED = 1'b0,
		SRC_CACHED   = 1'b1
	} src_t;

endpackage

// ==== hw/fetch_arbiter.sv ====
// Read address arbiter for the instruction fetch port
// Sticky two way select between the uncached fetch path and the
// cache refill path, with every request held off while the
// order queue is full

module fetch_arbiter
(
	input  logic                clk,
	input  logic                rstnn,

	input  ifetch_pkg::ar_req_t uc_ar,
	input  logic                uc_arvalid,
	output logic                uc_arready,

	input  ifetch_pkg::ar_req_t cc_ar,
	input  logic                cc_arvalid,
	output logic                cc_arready,

	output ifetch_pkg::ar_req_t bus_ar,
	output logic                bus_arvalid,
	input  logic                bus_arready,

	input  logic                order_full,
	output ifetch_pkg::src_t    sel
);

	logic sel_is_uc;
	logic sel_valid;

	////////////////////////////////////////////////////////////////////////////
	// Sticky select

	// Stays on a source while it keeps asking, so a burst of requests
	// from one master is not broken up by the other
	always_ff @(posedge clk, negedge rstnn)
	begin
		if (!rstnn)
			sel <= ifetch_pkg::SRC_UNCACHED;
		else
		begin
			case (sel)
				ifetch_pkg::SRC_UNCACHED:
					if (!uc_arvalid && cc_arvalid)
						sel <= ifetch_pkg::SRC_CACHED;
				ifetch_pkg::SRC_CACHED:
					if (!cc_arvalid && uc_arvalid)
						sel <= ifetch_pkg::SRC_UNCACHED;
				default:
					sel <= ifetch_pkg::SRC_UNCACHED;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Request multiplexing

	assign sel_is_uc = (sel == ifetch_pkg::SRC_UNCACHED);
	assign sel_valid = sel_is_uc ? uc_arvalid : cc_arvalid;

	always_comb
	begin
		bus_ar = cc_ar;
		if (sel_is_uc)
			bus_ar = uc_ar;
	end

	// No new request while every order slot is taken
	assign bus_arvalid = sel_valid & ~order_full;

	assign uc_arready = bus_arready & ~order_full & sel_is_uc;
	assign cc_arready = bus_arready & ~order_full & ~sel_is_uc;  // Unselected side sees low

endmodule

// ==== hw/order_queue.sv ====
// Request order queue
// Small circular FIFO of source tags, one per accepted read request.
// The head names the master that owns the oldest burst still
// returning data

module order_queue
#(
	parameter int ORDER_DEPTH = 3
)
(
	input  logic             clk,
	input  logic             rstnn,

	input  logic             push,
	input  ifetch_pkg::src_t push_src,
	input  logic             pop,

	output ifetch_pkg::src_t head_src,
	output logic             full
);

	localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
	localparam int CNT_W = $clog2(ORDER_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(ORDER_DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ORDER_DEPTH);

	ifetch_pkg::src_t tag_mem [ORDER_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             empty;
	logic             do_push;
	logic             do_pop;

	// Advance with wrap at the last slot
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == LAST_PTR)
			nxt = '0;
		else
			nxt = ptr + 1'b1;
		return nxt;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == FULL_CNT);
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	////////////////////////////////////////////////////////////////////////////
	// Tag storage

	always_ff @(posedge clk)
	begin
		if (do_push)
			tag_mem[wr_ptr] <= push_src;
	end

	// Idle steering points at the uncached side
	assign head_src = empty ? ifetch_pkg::SRC_UNCACHED : tag_mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk, negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);

			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle, or push and pop together
			endcase
		end
	end

endmodule

// ==== hw/ifetch_read_merge.sv ====
// Instruction side read merger
// Joins the uncached fetch master and the cache refill master onto
// one external read port. Requests go out through a sticky arbiter,
// and read beats return to whichever master owns the oldest
// outstanding burst

module ifetch_read_merge
#(
	parameter int ORDER_DEPTH = 3
)
(
	input  logic                clk,
	input  logic                rstnn,

	// Uncached fetch master
	input  ifetch_pkg::ar_req_t uc_ar,
	input  logic                uc_arvalid,
	output logic                uc_arready,
	output ifetch_pkg::r_beat_t uc_r,
	output logic                uc_rvalid,
	input  logic                uc_rready,

	// Cache refill master
	input  ifetch_pkg::ar_req_t cc_ar,
	input  logic                cc_arvalid,
	output logic                cc_arready,
	output ifetch_pkg::r_beat_t cc_r,
	output logic                cc_rvalid,
	input  logic                cc_rready,

	// External read port
	output ifetch_pkg::ar_req_t bus_ar,
	output logic                bus_arvalid,
	input  logic                bus_arready,
	input  ifetch_pkg::r_beat_t bus_r,
	input  logic                bus_rvalid,
	output logic                bus_rready
);

	ifetch_pkg::src_t sel;
	ifetch_pkg::src_t head_src;
	logic             order_full;
	logic             ar_fire;
	logic             r_last_fire;
	logic             head_is_uc;

	////////////////////////////////////////////////////////////////////////////
	// Request side

	fetch_arbiter u_arbiter
	(
		.clk         (clk),
		.rstnn       (rstnn),
		.uc_ar       (uc_ar),
		.uc_arvalid  (uc_arvalid),
		.uc_arready  (uc_arready),
		.cc_ar       (cc_ar),
		.cc_arvalid  (cc_arvalid),
		.cc_arready  (cc_arready),
		.bus_ar      (bus_ar),
		.bus_arvalid (bus_arvalid),
		.bus_arready (bus_arready),
		.order_full  (order_full),
		.sel         (sel)
	);

	assign ar_fire     = bus_arvalid & bus_arready;
	assign r_last_fire = bus_rvalid & bus_rready & bus_r.last;  // Burst done, owner retires

	order_queue
	#(
		.ORDER_DEPTH (ORDER_DEPTH)
	)
	u_order_queue
	(
		.clk      (clk),
		.rstnn    (rstnn),
		.push     (ar_fire),
		.push_src (sel),
		.pop      (r_last_fire),
		.head_src (head_src),
		.full     (order_full)
	);

	////////////////////////////////////////////////////////////////////////////
	// Response side

	assign head_is_uc = (head_src == ifetch_pkg::SRC_UNCACHED);

	// Only the owner of the oldest burst sees valid
	assign uc_rvalid = bus_rvalid & head_is_uc;
	assign cc_rvalid = bus_rvalid & ~head_is_uc;

	assign bus_rready = head_is_uc ? uc_rready : cc_rready;

	assign uc_r = bus_r;
	assign cc_r = bus_r;

endmodule

// ==== tests/ifetch_read_merge_sva.sv ====
// Bound checks for the instruction side read merger
// Request copying, sticky select, owner ordering of read beats
// and order queue back-pressure

module ifetch_read_merge_sva
#(
	parameter int ORDER_DEPTH = 3
)
(
	input logic                clk,
	input logic                rstnn,
	input ifetch_pkg::ar_req_t uc_ar, cc_ar, bus_ar,
	input ifetch_pkg::r_beat_t uc_r, cc_r, bus_r,
	input logic                uc_arvalid, uc_arready, uc_rvalid, uc_rready,
	input logic                cc_arvalid, cc_arready, cc_rvalid, cc_rready,
	input logic                bus_arvalid, bus_arready, bus_rvalid, bus_rready
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	ifetch_pkg::src_t    shadow [8];  // Owners of accepted requests, oldest at rd_idx
	logic [2:0]          wr_idx;
	logic [2:0]          rd_idx;
	int                  pending;
	logic                ar_fire;
	logic                last_fire;
	logic                owner_uc;
	logic                rready_expect;
	ifetch_pkg::ar_req_t ar_expect;
	ifetch_pkg::r_beat_t r_seen;

	function automatic void report_failure(input string msg);
		$error("%s", msg);
		fail_count++;
	endfunction

	assign ar_fire       = bus_arvalid & bus_arready;
	assign last_fire     = bus_rvalid & bus_rready & bus_r.last;
	assign owner_uc      = (shadow[rd_idx] == ifetch_pkg::SRC_UNCACHED);
	assign ar_expect     = uc_arready ? uc_ar : cc_ar;
	assign r_seen        = owner_uc ? uc_r : cc_r;
	assign rready_expect = owner_uc ? uc_rready : cc_rready;

	////////////////////////////////////////////////////////////////////////////
	// Shadow owner queue

	always_ff @(posedge clk, negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_idx  <= '0;
			rd_idx  <= '0;
			pending <= 0;
		end
		else
		begin
			if (ar_fire)
			begin
				shadow[wr_idx] <= cc_arready ? ifetch_pkg::SRC_CACHED
					: ifetch_pkg::SRC_UNCACHED;
				wr_idx         <= wr_idx + 1'b1;
			end
			if (last_fire)
				rd_idx <= rd_idx + 1'b1;
			pending <= pending + int'(ar_fire) - int'(last_fire);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	a_ar_idle: assert property (@(posedge clk) disable iff (!rstnn)
		!uc_arvalid && !cc_arvalid |-> !bus_arvalid)
		else report_failure("bus_arvalid went high while neither source was requesting");
	a_r_idle: assert property (@(posedge clk) disable iff (!rstnn)
		!bus_rvalid |-> !uc_rvalid && !cc_rvalid)
		else report_failure("A source rvalid went high while bus_rvalid was low");
	a_one_ready: assert property (@(posedge clk) disable iff (!rstnn)
		ar_fire |-> uc_arready ^ cc_arready)
		else report_failure("Bus AR transfer without exactly one source arready high");
	a_ar_copy: assert property (@(posedge clk) disable iff (!rstnn)
		ar_fire |-> bus_ar == ar_expect)
		else report_failure($sformatf("** Error %0t: bus_ar = %h, expected %h",
			$time, $sampled(bus_ar), $sampled(ar_expect)));
	a_sticky_uc: assert property (@(posedge clk) disable iff (!rstnn)
		uc_arvalid && $past(uc_arvalid && uc_arready) |-> !cc_arready)
		else report_failure("Select left the uncached source while it kept requesting");
	a_sticky_cc: assert property (@(posedge clk) disable iff (!rstnn)
		cc_arvalid && $past(cc_arvalid && cc_arready) |-> !uc_arready)
		else report_failure("Select left the refill source while it kept requesting");
	a_owner: assert property (@(posedge clk) disable iff (!rstnn)
		bus_rvalid |-> (owner_uc ? (uc_rvalid && !cc_rvalid) : (cc_rvalid && !uc_rvalid)))
		else report_failure("Read beat was not steered to the owner of the oldest request");
	a_r_copy: assert property (@(posedge clk) disable iff (!rstnn)
		bus_rvalid |-> r_seen == bus_r)
		else report_failure($sformatf("** Error %0t: owner r = %h, expected bus_r = %h",
			$time, $sampled(r_seen), $sampled(bus_r)));
	a_rready: assert property (@(posedge clk) disable iff (!rstnn)
		bus_rvalid |-> bus_rready == rready_expect)
		else report_failure($sformatf("** Error %0t: bus_rready = %b, expected %b",
			$time, $sampled(bus_rready), $sampled(rready_expect)));
	a_full: assert property (@(posedge clk) disable iff (!rstnn)
		pending == ORDER_DEPTH |-> !bus_arvalid && !uc_arready && !cc_arready)
		else report_failure("New request let through with every order slot taken");

endmodule

bind ifetch_read_merge ifetch_read_merge_sva #(.ORDER_DEPTH(ORDER_DEPTH)) u_sva (.*);

// ==== tests/tb_ifetch_read_merge.sv ====
// Testbench for the instruction side read merger
// Two random read masters and a bus slave with varying latency

module tb_ifetch_read_merge;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ORDER_DEPTH = 3;
	localparam int NUM_REQ     = 100;  // Per master
	localparam int BURST_CYC   = 80;   // Worst case cycles for one burst
	localparam int TIMEOUT_NS  = 2 * NUM_REQ * BURST_CYC * 10 + 2000;

	logic                clk         = 1'b0;
	logic                rstnn       = 1'b0;
	ifetch_pkg::ar_req_t uc_ar       = '0;
	ifetch_pkg::ar_req_t cc_ar       = '0;
	logic                uc_arvalid  = 1'b0;
	logic                cc_arvalid  = 1'b0;
	logic                uc_rready   = 1'b0;
	logic                cc_rready   = 1'b0;
	logic                bus_arready = 1'b0;
	ifetch_pkg::r_beat_t bus_r       = '0;
	logic                bus_rvalid  = 1'b0;
	logic                uc_arready, cc_arready, uc_rvalid, cc_rvalid;
	logic                bus_arvalid, bus_rready;
	ifetch_pkg::r_beat_t uc_r, cc_r;
	ifetch_pkg::ar_req_t bus_ar;

	// Handshakes seen at the last rising edge
	logic                uc_took = 1'b0;
	logic                cc_took = 1'b0;
	logic                ar_took = 1'b0;
	logic                r_took  = 1'b0;
	ifetch_pkg::ar_req_t ar_seen = '0;

	int                  uc_sent = 0;
	int                  cc_sent = 0;
	int                  beat    = 0;
	int                  hold    = 0;
	ifetch_pkg::ar_req_t slave_q[$];  // Accepted requests awaiting data

	ifetch_read_merge #(.ORDER_DEPTH(ORDER_DEPTH)) UUT (.*);

	always #5 clk = ~clk;

	function automatic ifetch_pkg::ar_req_t make_request(input logic cached, input int idx);
		ifetch_pkg::ar_req_t req;
		logic [31:0]         rnd;
		rnd       = $urandom;
		req.id    = rnd[ifetch_pkg::ID_W-1:0];
		req.addr  = (cached ? 32'h8000_0000 : 32'h0001_0000) + 32'(idx) * 32'h40;
		rnd       = $urandom_range(0, 3);
		req.len   = rnd[ifetch_pkg::LEN_W-1:0];
		req.size  = 3'd2;   // 4 byte beats
		req.burst = 2'b01;  // INCR
		return req;
	endfunction

	// Retire an accepted request, then maybe raise the next one
	function automatic void step_master(input logic took, input logic cached,
		inout logic arvalid, inout ifetch_pkg::ar_req_t ar, inout int sent);
		if (took)
			arvalid = 1'b0;
		if (!arvalid && sent < NUM_REQ && $urandom_range(0, 3) == 0)
		begin
			ar      = make_request(cached, sent);
			arvalid = 1'b1;
			sent++;
		end
	endfunction

	always @(posedge clk)
	begin
		uc_took <= uc_arvalid & uc_arready;
		cc_took <= cc_arvalid & cc_arready;
		ar_took <= bus_arvalid & bus_arready;
		r_took  <= bus_rvalid & bus_rready;
		ar_seen <= bus_ar;
	end

	////////////////////////////////////////////////////////////////////////////
	// Masters and slave, all driven on the falling edge

	always @(negedge clk)
	begin
		if (rstnn)
		begin
			step_master(uc_took, 1'b0, uc_arvalid, uc_ar, uc_sent);
			step_master(cc_took, 1'b1, cc_arvalid, cc_ar, cc_sent);
			uc_rready   = 1'($urandom_range(0, 1));
			cc_rready   = 1'($urandom_range(0, 1));
			bus_arready = ($urandom_range(0, 3) != 0);
			if (ar_took)
				slave_q.push_back(ar_seen);
			if (r_took)
			begin
				bus_rvalid = 1'b0;
				if (bus_r.last)
				begin
					void'(slave_q.pop_front());
					beat = 0;
				end
				else
					beat++;
			end
			if (hold > 0)
				hold--;
			else if (!bus_rvalid && slave_q.size() > 0)
			begin
				bus_r.id   = slave_q[0].id;
				bus_r.data = slave_q[0].addr + 32'(beat);
				bus_r.resp = '0;
				bus_r.last = (beat == int'(slave_q[0].len));
				bus_rvalid = 1'b1;
				if ($urandom_range(0, 15) == 0)
					hold = $urandom_range(8, 24);  // Stall so the order queue fills up
			end
		end
	end

	initial
	begin
		void'($urandom(32'h1b6010f3));
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstnn <= 1'b1;
		while (!(uc_sent == NUM_REQ && cc_sent == NUM_REQ && !uc_arvalid && !cc_arvalid
			&& slave_q.size() == 0))
			@(posedge clk);
		repeat (4) @(posedge clk);
		$display("Assertion failures: %0d, requests sent: %0d uncached, %0d cached",
			UUT.u_sva.fail_count, uc_sent, cc_sent);
		if (UUT.u_sva.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired with %0d accepted requests still waiting for data",
			slave_q.size());
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
hw/ifetch_pkg.sv
hw/fetch_arbiter.sv
hw/order_queue.sv
hw/ifetch_read_merge.sv
tests/ifetch_read_merge_sva.sv
tests/tb_ifetch_read_merge.sv

// ==== Makefile ====
# Verilator flow for the instruction side read merger

TOP = tb_ifetch_read_merge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
